//--- include/duc_params.svh
////////////////////////////////////////////////////////////
// Widths, register map and reset values of the DUC chain
// Included by the packages and the datapath modules
////////////////////////////////////////////////////////////

`ifndef DUC_PARAMS_SVH
`define DUC_PARAMS_SVH

// Datapath widths
`define DUC_SAMPLE_W 16
`define DUC_INTERP_W 10
`define DUC_PHASE_W 32

// Scale is Q1.14, so 16384 is unity gain
`define DUC_SCALE_FRAC 14

////////////////////////////////////////////////////////////
// User registers, shell space ends at 127
////////////////////////////////////////////////////////////
`define SR_INTERP_ADDR 8'd131
`define SR_FREQ_ADDR 8'd132
`define SR_SCALE_IQ_ADDR 8'd133

// Reset defaults
`define DUC_SCALE_RESET 16384
`define DUC_INTERP_RESET 1

`endif

//--- src/dsp_pkg.sv
////////////////////////////////////////////////////////////
// Sample and stream beat types shared by every stream
////////////////////////////////////////////////////////////

`include "duc_params.svh"

package dsp_pkg;

  // One complex sample, two's complement components
  typedef struct packed {
    logic signed [`DUC_SAMPLE_W-1:0] i;
    logic signed [`DUC_SAMPLE_W-1:0] q;
  } iq_t;

  // Payload of a valid/ready stream
  // last marks the end of a burst
  typedef struct packed {
    logic last;
    iq_t  iq;
  } beat_t;

endpackage

//--- src/ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Settings bus and decoded register types of the DUC
////////////////////////////////////////////////////////////

`include "duc_params.svh"

package ctrl_pkg;

  // Width of the IQ scale register
  localparam int SCALE_W = 16;

  // Host register write, one strobe per write
  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } set_bus_t;

  // Register file seen by the datapath stages
  typedef struct packed {
    logic [`DUC_INTERP_W-1:0] interp;
    logic [`DUC_PHASE_W-1:0]  freq;
    logic signed [SCALE_W-1:0] scale;
    logic                     freq_load;
  } duc_cfg_t;

endpackage

//--- src/duc_settings.sv
////////////////////////////////////////////////////////////
// User register file of the DUC, fed by settings bus writes
// Values reach o_cfg one cycle after the strobe
////////////////////////////////////////////////////////////

`include "duc_params.svh"

module duc_settings (
  input  logic                ce_clk,
  input  logic                i_rst,
  input  ctrl_pkg::set_bus_t  i_set,
  output ctrl_pkg::duc_cfg_t  o_cfg
);

  localparam logic [`DUC_INTERP_W-1:0] INTERP_DEFAULT = `DUC_INTERP_RESET;
  // Holding for zero beats makes no sense
  localparam logic [`DUC_INTERP_W-1:0] INTERP_MIN = 1;
  localparam logic signed [ctrl_pkg::SCALE_W-1:0] SCALE_DEFAULT = `DUC_SCALE_RESET;

  logic wr_interp;
  logic wr_freq;
  logic wr_scale;
  logic [`DUC_INTERP_W-1:0] interp_data;

  // Address decode
  assign wr_interp = i_set.stb && (i_set.addr == `SR_INTERP_ADDR);
  assign wr_freq   = i_set.stb && (i_set.addr == `SR_FREQ_ADDR);
  assign wr_scale  = i_set.stb && (i_set.addr == `SR_SCALE_IQ_ADDR);

  assign interp_data = i_set.data[`DUC_INTERP_W-1:0];

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_cfg.interp    <= INTERP_DEFAULT;
      o_cfg.freq      <= '0;
      o_cfg.scale     <= SCALE_DEFAULT;
      o_cfg.freq_load <= 1'b0;
    end else begin
      // Phase clear lasts exactly the cycle the new word shows up
      o_cfg.freq_load <= wr_freq;

      if (wr_interp) begin
        if (interp_data == '0) begin
          o_cfg.interp <= INTERP_MIN;
        end else begin
          o_cfg.interp <= interp_data;
        end
      end

      if (wr_freq) begin
        o_cfg.freq <= i_set.data[`DUC_PHASE_W-1:0];
      end

      if (wr_scale) begin
        o_cfg.scale <= i_set.data[ctrl_pkg::SCALE_W-1:0];
      end
    end
  end

endmodule

//--- src/sample_fifo.sv
////////////////////////////////////////////////////////////
// Small synchronous FIFO of stream beats, valid/ready on
// both sides, 2**DEPTH_LOG2 entries
////////////////////////////////////////////////////////////

module sample_fifo #(
  parameter int DEPTH_LOG2 = 2
) (
  input  logic            ce_clk,
  input  logic            i_rst,
  input  dsp_pkg::beat_t  i_beat,
  input  logic            i_valid,
  output logic            o_ready,
  output dsp_pkg::beat_t  o_beat,
  output logic            o_valid,
  input  logic            i_ready
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  dsp_pkg::beat_t mem [DEPTH];

  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  push;
  logic                  pop;

  assign o_ready = (count != DEPTH);
  assign o_valid = (count != 0);
  assign o_beat  = mem[rd_ptr];

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  // Storage
  always_ff @(posedge ce_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_beat;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/interp_hold.sv
////////////////////////////////////////////////////////////
// Zero-order hold interpolator, each input beat is sent
// i_interp times before the next one is taken
////////////////////////////////////////////////////////////

`include "duc_params.svh"

module interp_hold (
  input  logic                     ce_clk,
  input  logic                     i_rst,
  input  logic [`DUC_INTERP_W-1:0] i_interp,
  input  dsp_pkg::beat_t           i_beat,
  input  logic                     i_valid,
  output logic                     o_ready,
  output dsp_pkg::beat_t           o_beat,
  output logic                     o_valid,
  input  logic                     i_ready
);

  dsp_pkg::beat_t           hold_q;
  logic [`DUC_INTERP_W-1:0] remain;
  logic                     valid_q;
  logic                     final_copy;
  logic                     take;

  assign final_copy = (remain == 1);

  // Free once the last copy leaves, same cycle refill allowed
  assign o_ready = !valid_q || (i_ready && final_copy);
  assign take    = i_valid && o_ready;

  assign o_valid = valid_q;

  always_comb begin
    o_beat.iq   = hold_q.iq;
    // Burst end only on the closing copy
    o_beat.last = hold_q.last && final_copy;
  end

  always_ff @(posedge ce_clk) begin
    if (take) begin
      hold_q <= i_beat;
    end
  end

  ////////////////////////////////////////////////////////////
  // Repeat counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
      remain  <= '0;
    end else if (take) begin
      // Factor sampled with the beat
      valid_q <= 1'b1;
      remain  <= i_interp;
    end else if (valid_q && i_ready) begin
      if (final_copy) begin
        valid_q <= 1'b0;
      end else begin
        remain <= remain - 1'b1;
      end
    end
  end

endmodule

//--- src/quadrant_rotator.sv
////////////////////////////////////////////////////////////
// Coarse NCO mixer, rotates each sample by a multiple of
// 90 degrees picked from the phase accumulator MSBs
////////////////////////////////////////////////////////////

`include "duc_params.svh"

module quadrant_rotator (
  input  logic                    ce_clk,
  input  logic                    i_rst,
  input  logic [`DUC_PHASE_W-1:0] i_freq,
  input  logic                    i_freq_load,
  input  dsp_pkg::beat_t          i_beat,
  input  logic                    i_valid,
  output logic                    o_ready,
  output dsp_pkg::beat_t          o_beat,
  output logic                    o_valid,
  input  logic                    i_ready
);

  // Two's complement negate, clipped at full scale
  function automatic logic signed [`DUC_SAMPLE_W-1:0] neg_sat(
    input logic signed [`DUC_SAMPLE_W-1:0] x
  );
    logic signed [`DUC_SAMPLE_W-1:0] min_val;
    min_val = {1'b1, {(`DUC_SAMPLE_W-1){1'b0}}};
    if (x == min_val) begin
      return ~min_val;
    end
    return -x;
  endfunction

  logic [`DUC_PHASE_W-1:0] phase;
  logic [1:0]              quad;
  dsp_pkg::iq_t            rot;
  logic                    take;

  assign o_ready = !o_valid || i_ready;
  assign take    = i_valid && o_ready;
  assign quad    = phase[`DUC_PHASE_W-1 -: 2];

  always_comb begin
    case (quad)
      2'd0: begin
        rot.i = i_beat.iq.i;
        rot.q = i_beat.iq.q;
      end
      2'd1: begin
        rot.i = neg_sat(i_beat.iq.q);
        rot.q = i_beat.iq.i;
      end
      2'd2: begin
        rot.i = neg_sat(i_beat.iq.i);
        rot.q = neg_sat(i_beat.iq.q);
      end
      default: begin
        rot.i = i_beat.iq.q;
        rot.q = neg_sat(i_beat.iq.i);
      end
    endcase
  end

  always_ff @(posedge ce_clk) begin
    if (take) begin
      o_beat.iq   <= rot;
      o_beat.last <= i_beat.last;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
      phase   <= '0;
    end else begin
      if (take) begin
        o_valid <= 1'b1;
      end else if (i_ready) begin
        o_valid <= 1'b0;
      end
      // A new tuning word restarts the phase
      if (i_freq_load) begin
        phase <= '0;
      end else if (take) begin
        phase <= phase + i_freq;
      end
    end
  end

endmodule

//--- src/iq_scaler.sv
////////////////////////////////////////////////////////////
// Fixed-point gain on I and Q, floor shift then clip to the
// sample range, one register stage
////////////////////////////////////////////////////////////

`include "duc_params.svh"

module iq_scaler (
  input  logic                                 ce_clk,
  input  logic                                 i_rst,
  input  logic signed [ctrl_pkg::SCALE_W-1:0]  i_scale,
  input  dsp_pkg::beat_t                       i_beat,
  input  logic                                 i_valid,
  output logic                                 o_ready,
  output dsp_pkg::beat_t                       o_beat,
  output logic                                 o_valid,
  input  logic                                 i_ready
);

  localparam int PROD_W = `DUC_SAMPLE_W + ctrl_pkg::SCALE_W;
  localparam logic signed [PROD_W-1:0] MAX_V = (2 ** (`DUC_SAMPLE_W - 1)) - 1;
  localparam logic signed [PROD_W-1:0] MIN_V = -(2 ** (`DUC_SAMPLE_W - 1));

  // Multiply, arithmetic shift (rounds down), saturate
  function automatic logic signed [`DUC_SAMPLE_W-1:0] scale_sat(
    input logic signed [`DUC_SAMPLE_W-1:0]    x,
    input logic signed [ctrl_pkg::SCALE_W-1:0] s
  );
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] shifted;
    prod    = x * s;
    shifted = prod >>> `DUC_SCALE_FRAC;
    if (shifted > MAX_V) begin
      return MAX_V[`DUC_SAMPLE_W-1:0];
    end
    if (shifted < MIN_V) begin
      return MIN_V[`DUC_SAMPLE_W-1:0];
    end
    return shifted[`DUC_SAMPLE_W-1:0];
  endfunction

  dsp_pkg::iq_t scaled;
  logic         take;

  assign o_ready = !o_valid || i_ready;
  assign take    = i_valid && o_ready;

  always_comb begin
    scaled.i = scale_sat(i_beat.iq.i, i_scale);
    scaled.q = scale_sat(i_beat.iq.q, i_scale);
  end

  always_ff @(posedge ce_clk) begin
    if (take) begin
      o_beat.iq   <= scaled;
      o_beat.last <= i_beat.last;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else if (take) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

endmodule

//--- src/duc_chain_top.sv
////////////////////////////////////////////////////////////
// Digital up-conversion chain, ce_clk domain
// FIFO, hold interpolator, quadrant NCO, gain, FIFO
////////////////////////////////////////////////////////////

module duc_chain_top (
  input  logic                ce_clk,
  input  logic                i_rst,
  input  ctrl_pkg::set_bus_t  i_set,
  input  dsp_pkg::beat_t      i_beat,
  input  logic                i_valid,
  output logic                o_ready,
  output dsp_pkg::beat_t      o_out_beat,
  output logic                o_out_valid,
  input  logic                i_ready
);

  ctrl_pkg::duc_cfg_t cfg;

  dsp_pkg::beat_t fifo_beat, hold_beat, rot_beat, scl_beat;
  logic           fifo_valid, hold_valid, rot_valid, scl_valid;
  logic           fifo_ready, hold_ready, rot_ready, scl_ready;

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////
  duc_settings duc_settings_i (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_set(i_set), .o_cfg(cfg));

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////
  sample_fifo #(.DEPTH_LOG2(2)) in_fifo_i (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_beat(i_beat), .i_valid(i_valid), .o_ready(o_ready),
    .o_beat(fifo_beat), .o_valid(fifo_valid), .i_ready(fifo_ready));

  interp_hold interp_hold_i (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_interp(cfg.interp),
    .i_beat(fifo_beat), .i_valid(fifo_valid), .o_ready(fifo_ready),
    .o_beat(hold_beat), .o_valid(hold_valid), .i_ready(hold_ready));

  quadrant_rotator quadrant_rotator_i (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_freq(cfg.freq), .i_freq_load(cfg.freq_load),
    .i_beat(hold_beat), .i_valid(hold_valid), .o_ready(hold_ready),
    .o_beat(rot_beat), .o_valid(rot_valid), .i_ready(rot_ready));

  iq_scaler iq_scaler_i (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_scale(cfg.scale),
    .i_beat(rot_beat), .i_valid(rot_valid), .o_ready(rot_ready),
    .o_beat(scl_beat), .o_valid(scl_valid), .i_ready(scl_ready));

  // Two entry skid at the output
  sample_fifo #(.DEPTH_LOG2(1)) out_fifo_i (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_beat(scl_beat), .i_valid(scl_valid), .o_ready(scl_ready),
    .o_beat(o_out_beat), .o_valid(o_out_valid), .i_ready(i_ready));

endmodule

//--- test/tb_duc_chain.sv
////////////////////////////////////////////////////////////
// Self-checking testbench and simulation top of the DUC chain
// Random beats checked against a reference model under back-pressure
////////////////////////////////////////////////////////////

`include "duc_params.svh"

module tb_duc_chain;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_BEATS     = 188;
  localparam int TIMEOUT_CYC = N_BEATS * 512 * 4;

  // Expected output copy with a flag for the final copy of its input beat
  typedef struct packed {
    logic           fin;
    dsp_pkg::beat_t b;
  } exp_t;

  logic               ce_clk;
  logic               i_rst;
  ctrl_pkg::set_bus_t i_set;
  dsp_pkg::beat_t     i_beat;
  logic               i_valid;
  logic               o_ready;
  dsp_pkg::beat_t     o_out_beat;
  logic               o_out_valid;
  logic               i_ready;

  logic [31:0] stim_seed = 32'ha1db;
  logic [31:0] bp_seed   = 32'ha1db;
  logic        bp_on     = 1'b0;
  exp_t        exp_q[$];
  int          errors    = 0;
  int          checked   = 0;
  int          pending   = 0;

  // Reference model state
  int          m_interp  = `DUC_INTERP_RESET;
  int          m_scale   = `DUC_SCALE_RESET;
  logic [31:0] m_freq    = '0;
  logic [31:0] m_phase   = '0;

  duc_chain_top duc_chain_top_i (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_set(i_set),
    .i_beat(i_beat), .i_valid(i_valid), .o_ready(o_ready),
    .o_out_beat(o_out_beat), .o_out_valid(o_out_valid), .i_ready(i_ready));

  initial begin
    ce_clk = 1'b0;
    forever #20 ce_clk = ~ce_clk;
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and the reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] draw_stim();
    stim_seed = lcg(stim_seed);
    return stim_seed;
  endfunction

  function automatic int clip16(input int v);
    if (v > 32767) begin
      return 32767;
    end
    if (v < -32768) begin
      return -32768;
    end
    return v;
  endfunction

  function automatic int scale_ref(input int x, input int s);
    int p;
    p = x * s;
    // Arithmetic shift of a signed int floors
    return clip16(p >>> `DUC_SCALE_FRAC);
  endfunction

  function automatic dsp_pkg::beat_t make_beat();
    logic [31:0]    r;
    logic [31:0]    u;
    dsp_pkg::beat_t b;
    r = draw_stim();
    u = draw_stim();
    b.iq.i = r[31:16];
    b.iq.q = u[31:16];
    // Full-scale negative now and then to hit the negate clip
    if (r[2:0] == 3'd0) begin
      b.iq.i = 16'sh8000;
    end
    if (u[2:0] == 3'd0) begin
      b.iq.q = 16'sh8000;
    end
    b.last = (r[5:3] == 3'd0);
    return b;
  endfunction

  // Hold, rotate from the model phase, then scale
  task automatic model_push(input dsp_pkg::beat_t b);
    int   c;
    int   xi;
    int   xq;
    int   ri;
    int   rq;
    exp_t e;
    xi = int'($signed(b.iq.i));
    xq = int'($signed(b.iq.q));
    for (c = 1; c <= m_interp; c++) begin
      case (m_phase[31:30])
        2'd0: begin
          ri = xi;
          rq = xq;
        end
        2'd1: begin
          ri = clip16(-xq);
          rq = xi;
        end
        2'd2: begin
          ri = clip16(-xi);
          rq = clip16(-xq);
        end
        default: begin
          ri = xq;
          rq = clip16(-xi);
        end
      endcase
      e.fin     = (c == m_interp);
      e.b.last  = b.last && e.fin;
      e.b.iq.i  = 16'(scale_ref(ri, m_scale));
      e.b.iq.q  = 16'(scale_ref(rq, m_scale));
      exp_q.push_back(e);
      m_phase = m_phase + m_freq;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic signed [15:0] s16;
    i_set <= '{stb: 1'b1, addr: addr, data: data};
    @(posedge ce_clk);
    i_set.stb <= 1'b0;
    @(posedge ce_clk);
    s16 = data[15:0];
    case (addr)
      `SR_INTERP_ADDR: begin
        m_interp = (data[`DUC_INTERP_W-1:0] == 0) ? 1 : int'(data[`DUC_INTERP_W-1:0]);
      end
      `SR_FREQ_ADDR: begin
        m_freq  = data;
        m_phase = '0;
      end
      `SR_SCALE_IQ_ADDR: begin
        m_scale = s16;
      end
      default: begin
      end
    endcase
  endtask

  task automatic send_beats(input int n);
    int          k;
    int          gap;
    logic [31:0] r;
    logic        rdy;
    for (k = 0; k < n; k++) begin
      r   = draw_stim();
      gap = (r[1:0] == 2'd0) ? int'(r[3:2]) : 0;
      if (gap > 0) begin
        i_valid <= 1'b0;
        repeat (gap) @(posedge ce_clk);
      end
      i_beat  <= make_beat();
      i_valid <= 1'b1;
      rdy = 1'b0;
      // Ready is sampled mid-cycle and the transfer happens on the next edge
      while (!rdy) begin
        @(negedge ce_clk);
        rdy = o_ready;
        @(posedge ce_clk);
      end
    end
    i_valid <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge ce_clk);
    end
    repeat (2) @(posedge ce_clk);
  endtask

  // Output back-pressure of about 30 percent when enabled
  always @(posedge ce_clk) begin
    if (bp_on) begin
      bp_seed = lcg(bp_seed);
      i_ready <= (bp_seed[31:16] % 100) >= 30;
    end else begin
      i_ready <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////
  always @(posedge ce_clk) begin
    exp_t e;
    if (i_rst) begin
      assert (o_out_valid !== 1'b1) else begin
        errors++;
        $display("Error: t=%0t o_out_valid expected 0 got 1 during reset", $time);
      end
    end else begin
      // A full input FIFO also means the hold stage is stuck on one more beat
      assert (o_ready || pending >= 5) else begin
        errors++;
        $display("Error: t=%0t o_ready expected 1 got 0 with %0d beats in the chain",
                 $time, pending);
      end
      if (i_valid && o_ready) begin
        model_push(i_beat);
        pending++;
      end
      if (o_out_valid && i_ready) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("Output beat at t=%0t arrived when none was expected", $time);
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          checked++;
          if (e.fin) begin
            pending--;
          end
          assert (o_out_beat == e.b) else begin
            errors++;
            $display("Error: t=%0t expected %h got %h", $time, e.b, o_out_beat);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int          t;
    logic [31:0] r;
    i_rst   = 1'b1;
    i_set   = '0;
    i_beat  = '0;
    i_valid = 1'b0;
    i_ready = 1'b1;
    repeat (16) @(posedge ce_clk);
    i_rst <= 1'b0;
    @(posedge ce_clk);
    assert (o_ready) else begin
      errors++;
      $display("Error: t=%0t o_ready expected 1 got 0 after reset", $time);
    end

    // Defaults pass samples through unchanged
    send_beats(20);
    drain();

    // Interpolation where a zero factor is stored as one
    write_reg(`SR_INTERP_ADDR, 32'd0);
    send_beats(8);
    drain();
    for (t = 0; t < 3; t++) begin
      r = draw_stim();
      write_reg(`SR_INTERP_ADDR, {29'd0, r[2:0]} + 32'd2);
      send_beats(8);
      drain();
    end
    write_reg(`SR_INTERP_ADDR, 32'd1);

    // Quadrant rotation
    write_reg(`SR_FREQ_ADDR, 32'h4000_0000);
    send_beats(16);
    drain();
    for (t = 0; t < 2; t++) begin
      write_reg(`SR_FREQ_ADDR, draw_stim());
      send_beats(16);
      drain();
    end
    write_reg(`SR_FREQ_ADDR, 32'd0);

    // Scaling at both ends of the range and at a random value
    write_reg(`SR_SCALE_IQ_ADDR, 32'h0000_7fff);
    send_beats(16);
    drain();
    write_reg(`SR_SCALE_IQ_ADDR, 32'h0000_8000);
    send_beats(16);
    drain();
    write_reg(`SR_SCALE_IQ_ADDR, draw_stim());
    send_beats(16);
    drain();

    // Everything at once under back-pressure
    bp_on <= 1'b1;
    write_reg(`SR_INTERP_ADDR, 32'd3);
    write_reg(`SR_FREQ_ADDR, draw_stim());
    write_reg(`SR_SCALE_IQ_ADDR, draw_stim());
    send_beats(40);
    drain();

    $display("Checked %0d output beats, %0d errors, %0d beats still expected",
             checked, errors, exp_q.size());
    if (errors == 0 && exp_q.size() == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYC) @(posedge ce_clk);
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYC);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
src/dsp_pkg.sv
src/ctrl_pkg.sv
src/duc_settings.sv
src/sample_fifo.sv
src/interp_hold.sv
src/quadrant_rotator.sv
src/iq_scaler.sv
src/duc_chain_top.sv
test/tb_duc_chain.sv

//--- run_sim.sh
#!/bin/sh
# Build the DUC chain testbench with Verilator, run it and look for the pass line
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_duc_chain \
  -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb | grep -F "Result: PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
